/* hdl/vtp_pkg.sv */
// VTP shared definitions: table geometry, entry layout and the request, response and memory structs
package vtp_pkg;

    // ============================================================
    // Address geometry
    // ============================================================

    // Two table levels, each indexed by 9 bits of the VA page
    localparam int PT_IDX_WIDTH = 9;
    localparam int PT_MAX_DEPTH = 2;
    localparam int VA_PAGE_WIDTH = PT_IDX_WIDTH * PT_MAX_DEPTH;

    // A line holds 4 entries of 64 bits, so the low 2 index bits pick the word
    localparam int LINE_ADDR_WIDTH = 8;
    localparam int LINE_WORDS = 4;
    localparam int WORD_IDX_WIDTH = 2;
    localparam int LINE_IDX_WIDTH = PT_IDX_WIDTH - WORD_IDX_WIDTH;

    localparam int TLB_ENTRIES = 16;
    localparam int REQ_CREDITS = 4;

    typedef logic [VA_PAGE_WIDTH-1:0] t_va_page;
    typedef logic [LINE_ADDR_WIDTH-1:0] t_line_addr;
    typedef logic [LINE_WORDS-1:0][63:0] t_line_data;

    // Page table entry as software writes it into a line
    typedef struct packed {
        logic [47:0] unused;
        t_line_addr  pa_line;
        logic [5:0]  reserved;
        logic        invalid;
        logic        terminal;
    } t_pte;

    typedef struct packed {
        t_va_page va;
    } t_xlate_req;

    // Translation result, the fault flag replaces a valid PA
    typedef struct packed {
        t_va_page   va;
        t_line_addr pa_line;
        logic       fault;
    } t_xlate_rsp;

    typedef struct packed {
        logic       write;
        t_line_addr addr;
        t_line_data wdata;
    } t_mem_req;

endpackage

/* hdl/credit_fifo.sv */
// Circular FIFO for any payload type, with a registered pop strobe used as a credit return
`timescale 1ns/10ps

module credit_fifo #(
    parameter type payload_t = logic,
    parameter int DEPTH = 4
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t head,
    output logic     not_empty,
    output logic     credit_return
);

    localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_WIDTH = $clog2(DEPTH + 1);

    payload_t storage [DEPTH];
    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] rd_ptr;
    logic [CNT_WIDTH-1:0] count;
    logic do_push;
    logic do_pop;

    // A push into a full FIFO or a pop from an empty one is dropped
    assign do_push = push && (count != CNT_WIDTH'(DEPTH));
    assign do_pop = pop && not_empty;
    assign not_empty = (count != '0);
    assign head = storage[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (do_push)
        begin
            storage[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            credit_return <= 1'b0;
        end
        else
        begin
            // Pointers wrap explicitly so DEPTH need not be a power of two
            if (do_push)
            begin
                wr_ptr <= (wr_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop)
            begin
                rd_ptr <= (rd_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_WIDTH'(do_push) - CNT_WIDTH'(do_pop);
            // One credit goes back to the sender per entry that leaves
            credit_return <= do_pop;
        end
    end

endmodule

/* hdl/vtp_tlb.sv */
// Direct-mapped TLB with a registered lookup, fill from the walker and a whole-table flush
`timescale 1ns/10ps

module vtp_tlb (
    input  logic                clk,
    input  logic                reset,
    input  logic                lookup_valid,
    input  vtp_pkg::t_va_page   lookup_va,
    input  logic                fill_valid,
    input  vtp_pkg::t_xlate_rsp fill_rsp,
    input  logic                flush,
    output logic                hit,
    output logic                miss,
    output vtp_pkg::t_line_addr hit_pa
);

    import vtp_pkg::*;

    localparam int SET_WIDTH = $clog2(TLB_ENTRIES);
    localparam int TAG_WIDTH = VA_PAGE_WIDTH - SET_WIDTH;

    // Tag and PA arrays carry no reset, the valid bits alone mark live entries
    logic [TLB_ENTRIES-1:0] entry_valid;
    logic [TAG_WIDTH-1:0] entry_tag [TLB_ENTRIES];
    t_line_addr entry_pa [TLB_ENTRIES];

    logic [SET_WIDTH-1:0] lookup_set;
    logic [TAG_WIDTH-1:0] lookup_tag;
    logic [SET_WIDTH-1:0] fill_set;
    logic lookup_match;

    assign lookup_set = lookup_va[SET_WIDTH-1:0];
    assign lookup_tag = lookup_va[VA_PAGE_WIDTH-1:SET_WIDTH];
    assign fill_set = fill_rsp.va[SET_WIDTH-1:0];
    assign lookup_match = entry_valid[lookup_set] && (entry_tag[lookup_set] == lookup_tag);

    // ============================================================
    // Lookup, result one cycle after the request
    // ============================================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            hit <= 1'b0;
            miss <= 1'b0;
        end
        else
        begin
            hit <= lookup_valid && lookup_match;
            miss <= lookup_valid && !lookup_match;
        end
    end

    always_ff @(posedge clk)
    begin
        hit_pa <= entry_pa[lookup_set];
    end

    // ============================================================
    // Fill and flush
    // ============================================================

    // Faulting walks leave the table untouched so the fault is seen again
    always_ff @(posedge clk)
    begin
        if (fill_valid && !fill_rsp.fault)
        begin
            entry_tag[fill_set] <= fill_rsp.va[VA_PAGE_WIDTH-1:SET_WIDTH];
            entry_pa[fill_set] <= fill_rsp.pa_line;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset || flush)
        begin
            // A table write may change any mapping, so every entry goes
            entry_valid <= '0;
        end
        else if (fill_valid && !fill_rsp.fault)
        begin
            entry_valid[fill_set] <= 1'b1;
        end
    end

endmodule

/* hdl/vtp_pt_walk.sv */
// Page table walker that reads two table levels and returns the translation or a fault
`timescale 1ns/10ps

module vtp_pt_walk (
    input  logic                clk,
    input  logic                reset,
    input  logic                enable,
    input  vtp_pkg::t_line_addr root,
    input  logic                walk_start,
    input  vtp_pkg::t_va_page   walk_va,
    input  logic                rd_ready,
    input  vtp_pkg::t_line_data rd_data,
    input  logic                rd_data_valid,
    output logic                rd_valid,
    output vtp_pkg::t_line_addr rd_addr,
    output logic                done,
    output vtp_pkg::t_xlate_rsp result,
    output logic                walk_fault
);

    import vtp_pkg::*;

    typedef enum logic [1:0] {
        WALK_IDLE,
        WALK_READ,
        WALK_WAIT,
        WALK_DONE
    } t_walk_state;

    t_walk_state state;

    // Remaining VA index, the next level's 9 bits always sit at the top
    t_va_page va_idx;
    // Word of the line that holds the entry being read
    logic [WORD_IDX_WIDTH-1:0] word_idx;
    // Line address of the table page for the current level
    t_line_addr level_base;
    // Number of levels read so far
    logic [1:0] depth;

    logic [LINE_IDX_WIDTH-1:0] line_idx;
    t_pte entry;
    logic last_level;

    assign line_idx = va_idx[VA_PAGE_WIDTH-1 -: LINE_IDX_WIDTH];
    assign entry = rd_data[word_idx];
    assign last_level = (depth == 2'(PT_MAX_DEPTH));

    // The table page base plus the line index selects the line of this level
    assign rd_valid = (state == WALK_READ);
    assign rd_addr = level_base + LINE_ADDR_WIDTH'(line_idx);
    assign done = (state == WALK_DONE);

    // ============================================================
    // Walk state machine
    // ============================================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= WALK_IDLE;
            walk_fault <= 1'b0;
        end
        else
        begin
            case (state)
                WALK_IDLE:
                begin
                    if (walk_start)
                    begin
                        // Without a valid table there is nothing to walk
                        state <= enable ? WALK_READ : WALK_DONE;
                        walk_fault <= walk_fault || !enable;
                    end
                end
                WALK_READ:
                begin
                    // Address and valid hold until the arbiter grants
                    if (rd_ready)
                    begin
                        state <= WALK_WAIT;
                    end
                end
                WALK_WAIT:
                begin
                    if (rd_data_valid)
                    begin
                        if (entry.invalid || (entry.terminal != last_level))
                        begin
                            // Missing entry, or the walk ended at the wrong depth
                            state <= WALK_DONE;
                            walk_fault <= 1'b1;
                        end
                        else if (entry.terminal)
                        begin
                            state <= WALK_DONE;
                        end
                        else
                        begin
                            state <= WALK_READ;
                        end
                    end
                end
                default:
                begin
                    state <= WALK_IDLE;
                end
            endcase
        end
    end

    // ============================================================
    // Walk datapath
    // ============================================================

    always_ff @(posedge clk)
    begin
        if (state == WALK_IDLE)
        begin
            va_idx <= walk_va;
            level_base <= root;
            depth <= '0;
            result.va <= walk_va;
            result.pa_line <= '0;
            result.fault <= !enable;
        end
        else if (state == WALK_READ && rd_ready)
        begin
            word_idx <= va_idx[VA_PAGE_WIDTH-LINE_IDX_WIDTH-1 -: WORD_IDX_WIDTH];
            va_idx <= va_idx << PT_IDX_WIDTH;
            depth <= depth + 1'b1;
        end
        else if (state == WALK_WAIT && rd_data_valid)
        begin
            level_base <= entry.pa_line;
            result.pa_line <= entry.pa_line;
            result.fault <= entry.invalid || (entry.terminal != last_level);
        end
    end

endmodule

/* hdl/pt_mem_arbiter.sv */
// Two-way round-robin arbiter sharing the table memory between the walker and the load port
`timescale 1ns/10ps

module pt_mem_arbiter (
    input  logic                clk,
    input  logic                reset,
    input  logic                walk_valid,
    input  vtp_pkg::t_line_addr walk_addr,
    input  logic                load_valid,
    input  vtp_pkg::t_line_addr load_addr,
    input  vtp_pkg::t_line_data load_data,
    output logic                walk_ready,
    output logic                load_ready,
    output logic                mem_req_valid,
    output vtp_pkg::t_mem_req   mem_req,
    output logic                wrote
);

    // Set when the load port won the last grant
    logic last_load;

    // On a conflict the side that did not win last time goes first
    assign walk_ready = walk_valid && (!load_valid || last_load);
    assign load_ready = load_valid && !walk_ready;
    assign mem_req_valid = walk_ready || load_ready;

    always_comb
    begin
        mem_req.write = load_ready;
        mem_req.addr = load_ready ? load_addr : walk_addr;
        mem_req.wdata = load_data;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            last_load <= 1'b0;
            wrote <= 1'b0;
        end
        else
        begin
            if (mem_req_valid)
            begin
                last_load <= load_ready;
            end
            // The write lands this cycle, the TLB flush follows next cycle
            wrote <= load_ready;
        end
    end

endmodule

/* hdl/pt_mem.sv */
// Page table line memory with a registered read port and a write on granted requests
`timescale 1ns/10ps

module pt_mem (
    input  logic                clk,
    input  logic                mem_req_valid,
    input  vtp_pkg::t_mem_req   mem_req,
    output vtp_pkg::t_line_data rd_data,
    output logic                rd_data_valid
);

    import vtp_pkg::*;

    t_line_data lines [2**LINE_ADDR_WIDTH];

    always_ff @(posedge clk)
    begin
        if (mem_req_valid && mem_req.write)
        begin
            lines[mem_req.addr] <= mem_req.wdata;
        end
        rd_data <= lines[mem_req.addr];
        // Read data is valid exactly one cycle after a granted read
        rd_data_valid <= mem_req_valid && !mem_req.write;
    end

endmodule

/* hdl/vtp_top.sv */
// VTP top level joining the request FIFO, TLB, walker, memory arbiter and response register
`timescale 1ns/10ps

module vtp_top (
    input  logic                clk,
    input  logic                reset,
    input  logic                pt_enable,
    input  vtp_pkg::t_line_addr pt_root,
    input  logic                req_valid,
    input  vtp_pkg::t_xlate_req req,
    input  logic                load_valid,
    input  vtp_pkg::t_line_addr load_addr,
    input  vtp_pkg::t_line_data load_data,
    output logic                credit_return,
    output logic                rsp_valid,
    output vtp_pkg::t_xlate_rsp rsp,
    output logic                load_ready,
    output logic                walk_fault
);

    import vtp_pkg::*;

    t_xlate_req req_head;
    logic req_not_empty;
    logic req_pop;
    logic busy;
    t_va_page cur_va;
    logic hit;
    logic miss;
    t_line_addr hit_pa;
    logic hit_q;
    t_line_addr hit_pa_q;
    logic walk_done;
    t_xlate_rsp walk_result;
    logic rsp_push;
    t_xlate_rsp rsp_data;
    logic rd_valid;
    t_line_addr rd_addr;
    logic rd_ready;
    t_line_data rd_data;
    logic rd_data_valid;
    logic mem_req_valid;
    t_mem_req mem_req;
    logic tlb_flush;

    // ============================================================
    // Request admission
    // ============================================================

    // One translation is in flight at a time, from pop until its response
    assign req_pop = req_not_empty && !busy;
    assign rsp_push = hit_q || walk_done;
    assign rsp_data = hit_q ? '{va: cur_va, pa_line: hit_pa_q, fault: 1'b0} : walk_result;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy <= 1'b0;
            hit_q <= 1'b0;
        end
        else
        begin
            if (req_pop)
            begin
                busy <= 1'b1;
            end
            else if (rsp_push)
            begin
                busy <= 1'b0;
            end
            // Hits wait one cycle so they answer two cycles after the credit
            hit_q <= hit;
        end
    end

    always_ff @(posedge clk)
    begin
        if (req_pop)
        begin
            cur_va <= req_head.va;
        end
        hit_pa_q <= hit_pa;
    end

    credit_fifo #(
        .payload_t(t_xlate_req),
        .DEPTH(REQ_CREDITS)
    ) req_fifo_inst (
        .clk(clk),
        .reset(reset),
        .push(req_valid),
        .push_data(req),
        .pop(req_pop),
        .head(req_head),
        .not_empty(req_not_empty),
        .credit_return(credit_return)
    );

    vtp_tlb vtp_tlb_inst (
        .clk(clk),
        .reset(reset),
        .lookup_valid(req_pop),
        .lookup_va(req_head.va),
        .fill_valid(walk_done),
        .fill_rsp(walk_result),
        .flush(tlb_flush),
        .hit(hit),
        .miss(miss),
        .hit_pa(hit_pa)
    );

    // ============================================================
    // Walker and shared table memory
    // ============================================================

    vtp_pt_walk vtp_pt_walk_inst (
        .clk(clk),
        .reset(reset),
        .enable(pt_enable),
        .root(pt_root),
        .walk_start(miss),
        .walk_va(cur_va),
        .rd_ready(rd_ready),
        .rd_data(rd_data),
        .rd_data_valid(rd_data_valid),
        .rd_valid(rd_valid),
        .rd_addr(rd_addr),
        .done(walk_done),
        .result(walk_result),
        .walk_fault(walk_fault)
    );

    pt_mem_arbiter pt_mem_arbiter_inst (
        .clk(clk),
        .reset(reset),
        .walk_valid(rd_valid),
        .walk_addr(rd_addr),
        .load_valid(load_valid),
        .load_addr(load_addr),
        .load_data(load_data),
        .walk_ready(rd_ready),
        .load_ready(load_ready),
        .mem_req_valid(mem_req_valid),
        .mem_req(mem_req),
        .wrote(tlb_flush)
    );

    pt_mem pt_mem_inst (
        .clk(clk),
        .mem_req_valid(mem_req_valid),
        .mem_req(mem_req),
        .rd_data(rd_data),
        .rd_data_valid(rd_data_valid)
    );

    // Response output stage, drained every cycle so it never back-pressures
    credit_fifo #(
        .payload_t(t_xlate_rsp),
        .DEPTH(2)
    ) rsp_fifo_inst (
        .clk(clk),
        .reset(reset),
        .push(rsp_push),
        .push_data(rsp_data),
        .pop(rsp_valid),
        .head(rsp),
        .not_empty(rsp_valid),
        .credit_return()
    );

endmodule

/* verification/vtp_properties.sv */
// VTP protocol checker: bound assertions on credits, responses and walker read grants
`timescale 1ns/10ps

module vtp_properties (
    input logic clk,
    input logic reset,
    input logic req_valid,
    input logic credit_return,
    input logic rsp_valid,
    input logic rd_valid,
    input logic rd_ready
);

    import vtp_pkg::*;

    // Requests sent by the client whose credit has not come back yet
    logic [3:0] in_fifo;
    // Requests sent by the client that have no response yet
    logic [3:0] in_flight;
    // Cycles the walker has already held its read without a grant
    logic [2:0] read_wait;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            in_fifo <= '0;
            in_flight <= '0;
            read_wait <= '0;
        end
        else
        begin
            in_fifo <= in_fifo + 4'(req_valid) - 4'(credit_return);
            in_flight <= in_flight + 4'(req_valid) - 4'(rsp_valid);
            // Counts up while the arbiter stalls the walker, clears on grant
            read_wait <= (rd_valid && !rd_ready) ? read_wait + 3'd1 : 3'd0;
        end
    end

    // ============================================================
    // Protocol rules
    // ============================================================

    credit_limit: assert property (@(posedge clk) disable iff (reset)
        in_fifo <= 4'(REQ_CREDITS))
        else $error("Client holds more requests in the FIFO than it has credits");

    credit_with_request: assert property (@(posedge clk) disable iff (reset)
        credit_return |-> (in_fifo != 4'd0))
        else $error("Credit returned while no request was waiting");

    response_with_request: assert property (@(posedge clk) disable iff (reset)
        rsp_valid |-> (in_flight != 4'd0))
        else $error("Response issued with no request outstanding");

    // The round-robin arbiter must let the walker in within 2 cycles
    read_grant_latency: assert property (@(posedge clk) disable iff (reset)
        (rd_valid && !rd_ready) |-> (read_wait < 3'd2))
        else $error("Walker read was not granted within 2 cycles");

endmodule

bind vtp_top vtp_properties vtp_properties_inst (
    .clk(clk),
    .reset(reset),
    .req_valid(req_valid),
    .credit_return(credit_return),
    .rsp_valid(rsp_valid),
    .rd_valid(rd_valid),
    .rd_ready(rd_ready)
);

/* verification/vtp_tb.sv */
// VTP testbench that loads a two-level page table, issues translations under credits and checks results
`timescale 1ns/10ps

module vtp_tb;

    import vtp_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int RESET_CYCLES = 8;
    localparam int SEED = 44008;
    localparam int NUM_LINES = 2 ** LINE_ADDR_WIDTH;
    localparam int NUM_REQUESTS = 17;
    // Each table line load takes one cycle and each request gets a generous walk budget
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + 2 * NUM_LINES + 200 * NUM_REQUESTS;
    localparam t_line_addr ROOT = 8'h40;
    // Every first level entry points at the same second level table page that wraps past line 255
    localparam t_line_addr L2_BASE = 8'hC0;

    // Outcome classes of a walk in the reference model
    localparam int KIND_MAPPED = 0;
    localparam int KIND_L1_INVALID = 1;
    localparam int KIND_L2_INVALID = 2;
    localparam int KIND_L2_NONTERM = 3;

    logic clk;
    logic reset;
    logic pt_enable;
    t_line_addr pt_root;
    logic req_valid;
    t_xlate_req req;
    logic load_valid;
    t_line_addr load_addr;
    t_line_data load_data;
    logic credit_return;
    logic rsp_valid;
    t_xlate_rsp rsp;
    logic load_ready;
    logic walk_fault;

    // Copy of the table as software wrote it
    t_line_data model_lines [NUM_LINES];
    t_xlate_rsp exp_rsp_q [$];
    bit exp_hit_q [$];
    string exp_name_q [$];
    int credit_cycle_q [$];
    int cycle = 0;
    int issued = 0;
    int returned = 0;
    int checks = 0;
    int errors = 0;

    vtp_top vtp_top_inst (
        .clk(clk),
        .reset(reset),
        .pt_enable(pt_enable),
        .pt_root(pt_root),
        .req_valid(req_valid),
        .req(req),
        .load_valid(load_valid),
        .load_addr(load_addr),
        .load_data(load_data),
        .credit_return(credit_return),
        .rsp_valid(rsp_valid),
        .rsp(rsp),
        .load_ready(load_ready),
        .walk_fault(walk_fault)
    );

    // ============================================================
    // Table contents and reference walk
    // ============================================================

    // Entry bits depend on the line and the word so every entry is distinct
    function automatic t_line_data make_line(input int line);
        t_line_data data;
        t_pte entry;
        int flat;
        for (int w = 0; w < LINE_WORDS; w++)
        begin
            flat = line * LINE_WORDS + w;
            entry = '0;
            entry.unused = 48'(flat);
            // Level 1 takes the 128 lines from ROOT upwards and level 2 the rest
            if (t_line_addr'(line - int'(ROOT)) < t_line_addr'(1 << LINE_IDX_WIDTH))
            begin
                entry.pa_line = L2_BASE;
                entry.invalid = (flat % 7 == 3);
            end
            else
            begin
                entry.pa_line = 8'(flat * 37 + 11);
                entry.invalid = (flat % 5 == 2);
                entry.terminal = (flat % 6 != 1);
            end
            data[w] = entry;
        end
        return data;
    endfunction

    function automatic t_xlate_rsp model_walk(input t_va_page va, output int kind,
                                              output t_line_addr l2_line);
        t_xlate_rsp expected;
        t_line_addr l1_line;
        t_pte l1;
        t_pte l2;
        // The top 9 bits index level 1 with 7 bits for the line and 2 for the word
        l1_line = ROOT + t_line_addr'(va[17:11]);
        l1 = model_lines[l1_line][va[10:9]];
        l2_line = l1.pa_line + t_line_addr'(va[8:2]);
        l2 = model_lines[l2_line][va[1:0]];
        expected.va = va;
        expected.pa_line = '0;
        expected.fault = 1'b1;
        // A terminal entry is only legal at the last level
        if (l1.invalid || l1.terminal)
            kind = KIND_L1_INVALID;
        else if (l2.invalid)
            kind = KIND_L2_INVALID;
        else if (!l2.terminal)
            kind = KIND_L2_NONTERM;
        else
        begin
            kind = KIND_MAPPED;
            expected.pa_line = l2.pa_line;
            expected.fault = 1'b0;
        end
        return expected;
    endfunction

    // Scans from a random start for the first VA with the wanted outcome outside avoid_l2
    function automatic t_va_page find_va(input int want_kind, input int avoid_l2);
        t_va_page start;
        t_va_page va;
        t_line_addr l2_line;
        int kind;
        start = t_va_page'($urandom);
        for (int i = 0; i < (1 << VA_PAGE_WIDTH); i++)
        begin
            va = start + t_va_page'(i);
            void'(model_walk(va, kind, l2_line));
            if (kind == want_kind && int'(l2_line) != avoid_l2)
                return va;
        end
        return start;
    endfunction

    // ============================================================
    // Checking
    // ============================================================

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        assert (actual == expected)
        else
        begin
            errors++;
            $display("FAIL %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
        end
    endtask

    task automatic check_response();
        t_xlate_rsp expected;
        bit expect_hit;
        string name;
        int credit_cycle;
        if (exp_rsp_q.size() == 0)
        begin
            errors++;
            $display("Response for va 0x%0h arrived with no request outstanding", rsp.va);
        end
        else
        begin
            expected = exp_rsp_q.pop_front();
            expect_hit = exp_hit_q.pop_front();
            name = exp_name_q.pop_front();
            credit_cycle = 0;
            if (credit_cycle_q.size() != 0)
                credit_cycle = credit_cycle_q.pop_front();
            check_value({name, " va"}, expected.va, rsp.va);
            check_value({name, " fault"}, expected.fault, rsp.fault);
            // The PA of a faulting walk carries no meaning
            if (!expected.fault)
                check_value({name, " pa_line"}, expected.pa_line, rsp.pa_line);
            if (expect_hit)
                check_value({name, " cycles after credit"}, 2, cycle - credit_cycle);
        end
    endtask

    // Outputs are sampled on the falling edge half a cycle after they change
    always @(negedge clk)
    begin
        cycle++;
        if (!reset)
        begin
            if (credit_return)
            begin
                returned++;
                credit_cycle_q.push_back(cycle);
            end
            if (rsp_valid)
                check_response();
        end
    end

    // ============================================================
    // Stimulus
    // ============================================================

    // Callers start on a falling edge and return on one
    task automatic write_line(input t_line_addr addr, input t_line_data data);
        logic granted;
        granted = 1'b0;
        load_valid = 1'b1;
        load_addr = addr;
        load_data = data;
        while (!granted)
        begin
            // The grant is combinational and is read well ahead of the rising edge
            #(CLK_PERIOD / 4);
            granted = load_ready;
            @(negedge clk);
        end
        load_valid = 1'b0;
    endtask

    task automatic issue_request(input t_va_page va, input bit expect_hit, input string name);
        int kind;
        t_line_addr l2_line;
        while (issued - returned >= REQ_CREDITS)
            @(negedge clk);
        exp_rsp_q.push_back(model_walk(va, kind, l2_line));
        exp_hit_q.push_back(expect_hit);
        exp_name_q.push_back(name);
        req_valid = 1'b1;
        req.va = va;
        issued++;
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic wait_responses();
        while (exp_rsp_q.size() != 0)
            @(negedge clk);
    endtask

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Some tests failed");
        $finish;
    end

    initial
    begin
        t_va_page va_x;
        t_line_addr x_l2;
        t_line_data new_line;
        t_pte new_entry;
        int kind;
        void'($urandom(SEED));
        reset = 1'b1;
        pt_enable = 1'b1;
        pt_root = ROOT;
        req_valid = 1'b0;
        req = '0;
        load_valid = 1'b0;
        load_addr = '0;
        load_data = '0;
        va_x = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;

        // Software builds the whole table through the load port
        for (int line = 0; line < NUM_LINES; line++)
        begin
            model_lines[line] = make_line(line);
            write_line(t_line_addr'(line), model_lines[line]);
        end
        repeat (2) @(negedge clk);

        // The last mapped VA stays cached for the hit checks
        for (int i = 0; i < 4; i++)
        begin
            va_x = find_va(KIND_MAPPED, -1);
            issue_request(va_x, 1'b0, "mapped walk");
        end
        wait_responses();
        check_value("walk_fault before faults", 0, walk_fault);
        for (int i = 0; i < 2; i++)
        begin
            issue_request(va_x, 1'b1, "tlb hit");
            wait_responses();
        end

        // Invalid entries at both levels come first and then a walk that runs out of depth
        issue_request(find_va(KIND_L1_INVALID, -1), 1'b0, "l1 invalid");
        issue_request(find_va(KIND_L2_INVALID, -1), 1'b0, "l2 invalid");
        wait_responses();
        check_value("walk_fault after faults", 1, walk_fault);
        issue_request(find_va(KIND_L2_NONTERM, -1), 1'b0, "depth limit");
        wait_responses();

        // Remap the cached VA while other walks share the table memory
        void'(model_walk(va_x, kind, x_l2));
        new_line = model_lines[x_l2];
        new_entry = new_line[va_x[1:0]];
        new_entry.pa_line = ~new_entry.pa_line;
        new_line[va_x[1:0]] = new_entry;
        fork
            begin
                for (int i = 0; i < 3; i++)
                    issue_request(find_va(KIND_MAPPED, int'(x_l2)), 1'b0, "shared memory walk");
            end
            begin
                repeat (3) @(negedge clk);
                write_line(x_l2, new_line);
                model_lines[x_l2] = new_line;
            end
        join
        wait_responses();
        issue_request(va_x, 1'b0, "rewritten entry");
        wait_responses();

        // All credits are spent back to back with one request of each outcome
        for (int i = 0; i < REQ_CREDITS; i++)
            issue_request(find_va(i % 4, -1), 1'b0, "credit burst");
        wait_responses();
        repeat (2) @(negedge clk);
        check_value("credits returned", REQ_CREDITS, REQ_CREDITS - issued + returned);

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

/* sources.f */
hdl/vtp_pkg.sv
hdl/credit_fifo.sv
hdl/vtp_tlb.sv
hdl/vtp_pt_walk.sv
hdl/pt_mem_arbiter.sv
hdl/pt_mem.sv
hdl/vtp_top.sv
verification/vtp_properties.sv
verification/vtp_tb.sv

/* run.sh */
#!/bin/sh
# Builds the VTP testbench with Verilator, runs it and checks the result

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module vtp_tb; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vvtp_tb)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "All tests passed"; then
    exit 0
fi
exit 1
